// File: sha256_pkg.sv
// ============================================================
// SHA-256 accelerator shared definitions
// Widths and types, FSM state encoding
// Round constants, initial hash value, register map
// Word functions for schedule and round datapath
// ============================================================

package sha256_pkg;

    // Data widths with meaning
    typedef logic [31:0]  word_t;
    typedef logic [7:0]   byte_t;
    typedef logic [63:0]  bit_len_t;
    typedef logic [5:0]   round_t;
    typedef logic [6:0]   byte_ptr_t;
    typedef logic [511:0] block_t;
    typedef logic [255:0] digest_t;
    typedef logic [63:0]  bus_data_t;
    typedef logic [5:0]   reg_addr_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE,
        PAD_MARK,
        PAD_FILL,
        PAD_SPILL,
        PAD_LEN,
        LOAD,
        ROUND,
        DONE
    } sha_state_t;

    // ============================================================
    // Constants
    // ============================================================

    // FIPS 180-4 round constants, round 0 first
    localparam word_t K_TABLE [0:63] = '{
        32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
        32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
        32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
        32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
        32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
        32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
        32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
        32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
        32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
        32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
        32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
        32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
        32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
        32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
        32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
        32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
    };

    // Initial hash, H0 in the top word
    localparam digest_t IV_HASH = {
        32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
        32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
    };

    // Register offsets
    localparam reg_addr_t REG_CMD        = 6'h00;
    localparam reg_addr_t REG_STATUS     = 6'h08;
    localparam reg_addr_t REG_DIN        = 6'h10;
    localparam reg_addr_t REG_DOUT_FIRST = 6'h18;
    localparam reg_addr_t REG_DOUT_LAST  = 6'h37;

    // Command codes in CMD bits 2:0
    localparam logic [2:0] CMD_INIT  = 3'd1;
    localparam logic [2:0] CMD_FINAL = 3'd3;

    // ============================================================
    // Word functions
    // ============================================================

    function automatic word_t k_const(round_t i);
        return K_TABLE[i];
    endfunction

    function automatic word_t rotr(word_t x, int unsigned n);
        return (x >> n) | (x << (32 - n));
    endfunction

    function automatic word_t big_sigma0(word_t x);
        return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
    endfunction

    function automatic word_t big_sigma1(word_t x);
        return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
    endfunction

    function automatic word_t small_sigma0(word_t x);
        return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
    endfunction

    function automatic word_t small_sigma1(word_t x);
        return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
    endfunction

    // Choice: bits of e select between f and g
    function automatic word_t ch(word_t e, word_t f, word_t g);
        return (e & f) ^ (~e & g);
    endfunction

    // Majority of three
    function automatic word_t maj(word_t a, word_t b, word_t c);
        return (a & b) ^ (a & c) ^ (b & c);
    endfunction

endpackage

// File: sha256_mmio_regs.sv
// ============================================================
// Register block of the SHA-256 accelerator
// Write decode into command and byte strobes
// STATUS and digest byte read-back, one-cycle ack
// ============================================================

`timescale 1ns/1ps

module sha256_mmio_regs
    import sha256_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  reg_addr_t addr,
    input  bus_data_t wdata,
    input  logic      wen,
    input  logic      busy,
    input  logic      done,
    input  digest_t   digest,
    output bus_data_t rdata,
    output logic      ack,
    output logic      cmd_init,
    output logic      cmd_final,
    output logic      din_wr,
    output byte_t     din_byte
);

    logic       wr_ok;
    logic [4:0] dout_idx;

    // Writes only count while the engine is idle
    assign wr_ok = req && wen && !busy;

    assign cmd_init  = wr_ok && (addr == REG_CMD) && (wdata[2:0] == CMD_INIT);
    assign cmd_final = wr_ok && (addr == REG_CMD) && (wdata[2:0] == CMD_FINAL);
    assign din_wr    = wr_ok && (addr == REG_DIN);
    assign din_byte  = wdata[7:0];

    // Digest byte number, byte 0 is the top byte of H0
    assign dout_idx = 5'(addr - REG_DOUT_FIRST);

    // ============================================================
    // Read path and ack
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack   <= 1'b0;
            rdata <= '0;
        end else begin
            ack   <= req;
            rdata <= '0;
            if (req && !wen) begin
                if (addr == REG_STATUS) begin
                    // Bit 0 busy, bit 1 done
                    rdata <= bus_data_t'({done, busy});
                end else if (addr >= REG_DOUT_FIRST && addr <= REG_DOUT_LAST) begin
                    rdata <= bus_data_t'(digest[8 * (31 - dout_idx) +: 8]);
                end
            end
        end
    end

endmodule

// File: sha256_ctrl.sv
// ============================================================
// SHA-256 sequencing FSM
// Padding steps, block load, round counter, feed-forward
// Busy, done and interrupt generation
// ============================================================

`timescale 1ns/1ps

module sha256_ctrl
    import sha256_pkg::*;
#(
    parameter int NUM_ROUNDS = 64
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   cmd_init,
    input  logic   cmd_final,
    input  logic   block_full,
    input  logic   len_fits,
    output logic   load,
    output logic   step,
    output logic   finish,
    output round_t round,
    output logic   pad_mark,
    output logic   pad_fill,
    output logic   pad_spill,
    output logic   pad_len_only,
    output logic   busy,
    output logic   done,
    output logic   irq
);

    localparam round_t LAST_ROUND = round_t'(NUM_ROUNDS - 1);

    sha_state_t state;
    // FINAL in progress
    logic       fin_active;
    // Running compression ends the message
    logic       fin_last;

    // Strobes follow the state directly
    assign pad_mark     = (state == PAD_MARK);
    assign pad_fill     = (state == PAD_FILL);
    assign pad_spill    = (state == PAD_SPILL);
    assign pad_len_only = (state == PAD_LEN);
    assign load         = (state == LOAD);
    assign step         = (state == ROUND);
    assign finish       = (state == DONE);

    // A full block counts as busy before LOAD is reached
    assign busy = (state != IDLE) || block_full;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            round      <= '0;
            fin_active <= 1'b0;
            fin_last   <= 1'b0;
            done       <= 1'b0;
            irq        <= 1'b0;
        end else begin
            irq <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_init) begin
                        done       <= 1'b0;
                        fin_active <= 1'b0;
                        fin_last   <= 1'b0;
                    end else if (cmd_final) begin
                        done       <= 1'b0;
                        fin_active <= 1'b1;
                        state      <= PAD_MARK;
                    end else if (block_full) begin
                        state <= LOAD;
                    end
                end
                // Length fits behind the marker or spills to a second block
                PAD_MARK: state <= len_fits ? PAD_FILL : PAD_SPILL;
                PAD_FILL: begin
                    fin_last <= 1'b1;
                    state    <= LOAD;
                end
                PAD_SPILL: state <= LOAD;
                PAD_LEN: begin
                    fin_last <= 1'b1;
                    state    <= LOAD;
                end
                LOAD: begin
                    round <= '0;
                    state <= ROUND;
                end
                ROUND: begin
                    if (round == LAST_ROUND) begin
                        state <= DONE;
                    end else begin
                        round <= round + 6'd1;
                    end
                end
                DONE: begin
                    if (fin_last) begin
                        // Digest ready in the hash state
                        done       <= 1'b1;
                        irq        <= 1'b1;
                        fin_active <= 1'b0;
                        fin_last   <= 1'b0;
                        state      <= IDLE;
                    end else if (fin_active) begin
                        state <= PAD_LEN;
                    end else begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// File: sha256_block_buffer.sv
// ============================================================
// SHA-256 64-byte block buffer
// Byte pointer, message bit length, padding writes
// ============================================================

`timescale 1ns/1ps

module sha256_block_buffer
    import sha256_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_init,
    input  logic      din_wr,
    input  byte_t     din_byte,
    input  logic      pad_mark,
    input  logic      pad_fill,
    input  logic      pad_spill,
    input  logic      pad_len_only,
    input  logic      load,
    output block_t    block,
    output logic      block_full,
    output logic      len_fits
);

    byte_t     buf_mem [0:63];
    byte_ptr_t ptr;
    bit_len_t  bit_len;

    // Room for 0x80 plus the 8 length bytes
    assign len_fits = (ptr < 7'd56);

    // Byte 0 lands in the top bits, so words come out big-endian
    always_comb begin
        for (int i = 0; i < 64; i++) begin
            block[511 - 8 * i -: 8] = buf_mem[i];
        end
    end

    // ============================================================
    // Pointer, length and full pulse
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr        <= '0;
            bit_len    <= '0;
            block_full <= 1'b0;
        end else begin
            block_full <= din_wr && (ptr == 7'd63);
            if (cmd_init || load) begin
                ptr <= '0;
            end else if (din_wr) begin
                ptr <= ptr + 7'd1;
            end
            if (cmd_init) begin
                bit_len <= '0;
            end else if (din_wr) begin
                bit_len <= bit_len + 64'd8;
            end
        end
    end

    // ============================================================
    // Byte storage and padding
    // ============================================================
    always_ff @(posedge clk) begin
        if (din_wr) begin
            buf_mem[ptr[5:0]] <= din_byte;
        end
        if (pad_mark) begin
            buf_mem[ptr[5:0]] <= 8'h80;
        end
        // Zeros after the marker, length in the tail
        for (int i = 0; i < 64; i++) begin
            if (pad_fill && i > ptr && i < 56) begin
                buf_mem[i] <= 8'h00;
            end
            if (pad_spill && i > ptr) begin
                buf_mem[i] <= 8'h00;
            end
            if (pad_len_only && i < 56) begin
                buf_mem[i] <= 8'h00;
            end
        end
        if (pad_fill || pad_len_only) begin
            for (int j = 0; j < 8; j++) begin
                buf_mem[56 + j] <= bit_len[63 - 8 * j -: 8];
            end
        end
    end

endmodule

// File: sha256_msg_schedule.sv
// ============================================================
// SHA-256 message schedule
// 16-word rolling window with expansion for rounds 16 to 63
// ============================================================

`timescale 1ns/1ps

module sha256_msg_schedule
    import sha256_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   load,
    input  block_t block,
    input  logic   step,
    input  round_t round,
    output word_t  w_cur
);

    word_t      win [0:15];
    logic [3:0] slot;
    word_t      w_new;

    // Slot holds W[t-16] before it is overwritten by W[t]
    assign slot  = round[3:0];
    assign w_new = small_sigma1(win[slot + 4'd14]) + win[slot + 4'd9]
                 + small_sigma0(win[slot + 4'd1]) + win[slot];

    // First 16 rounds read the block words as loaded
    assign w_cur = (round < 6'd16) ? win[slot] : w_new;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                win[i] <= '0;
            end
        end else if (load) begin
            for (int i = 0; i < 16; i++) begin
                win[i] <= block[511 - 32 * i -: 32];
            end
        end else if (step && round >= 6'd16) begin
            win[slot] <= w_new;
        end
    end

endmodule

// File: sha256_round_core.sv
// ============================================================
// SHA-256 round core
// Working variables a..h and the round function
// Hash state with init and feed-forward
// ============================================================

`timescale 1ns/1ps

module sha256_round_core
    import sha256_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_init,
    input  logic    load,
    input  logic    step,
    input  logic    finish,
    input  round_t  round,
    input  word_t   w_cur,
    output digest_t digest
);

    word_t hash [0:7];
    word_t a, b, c, d, e, f, g, h;
    word_t t1;
    word_t t2;

    // Round function temporaries
    assign t1 = h + big_sigma1(e) + ch(e, f, g) + k_const(round) + w_cur;
    assign t2 = big_sigma0(a) + maj(a, b, c);

    // H0 in the top word
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            digest[255 - 32 * i -: 32] = hash[i];
        end
    end

    // ============================================================
    // Hash state
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                hash[i] <= IV_HASH[255 - 32 * i -: 32];
            end
        end else if (cmd_init) begin
            for (int i = 0; i < 8; i++) begin
                hash[i] <= IV_HASH[255 - 32 * i -: 32];
            end
        end else if (finish) begin
            // Feed-forward of the compressed block
            hash[0] <= hash[0] + a;
            hash[1] <= hash[1] + b;
            hash[2] <= hash[2] + c;
            hash[3] <= hash[3] + d;
            hash[4] <= hash[4] + e;
            hash[5] <= hash[5] + f;
            hash[6] <= hash[6] + g;
            hash[7] <= hash[7] + h;
        end
    end

    // Working variables
    always_ff @(posedge clk) begin
        if (load) begin
            {a, b, c, d} <= {hash[0], hash[1], hash[2], hash[3]};
            {e, f, g, h} <= {hash[4], hash[5], hash[6], hash[7]};
        end else if (step) begin
            a <= t1 + t2;
            b <= a;
            c <= b;
            d <= c;
            e <= d + t1;
            f <= e;
            g <= f;
            h <= g;
        end
    end

endmodule

// File: sha256_accel.sv
// ============================================================
// SHA-256 accelerator top level
// Register block, sequencer, block buffer,
// message schedule and round core
// ============================================================

`timescale 1ns/1ps

module sha256_accel
    import sha256_pkg::*;
#(
    parameter int NUM_ROUNDS = 64
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req,
    input  reg_addr_t addr,
    input  bus_data_t wdata,
    input  logic      wen,
    output bus_data_t rdata,
    output logic      ack,
    output logic      irq
);

    // Register block strobes
    logic    cmd_init;
    logic    cmd_final;
    logic    din_wr;
    byte_t   din_byte;

    // Sequencer status and control
    logic    busy;
    logic    done;
    logic    load;
    logic    step;
    logic    finish;
    round_t  round;
    logic    pad_mark;
    logic    pad_fill;
    logic    pad_spill;
    logic    pad_len_only;

    // Buffer and datapath
    logic    block_full;
    logic    len_fits;
    block_t  block;
    word_t   w_cur;
    digest_t digest;

    sha256_mmio_regs u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .addr      (addr),
        .wdata     (wdata),
        .wen       (wen),
        .busy      (busy),
        .done      (done),
        .digest    (digest),
        .rdata     (rdata),
        .ack       (ack),
        .cmd_init  (cmd_init),
        .cmd_final (cmd_final),
        .din_wr    (din_wr),
        .din_byte  (din_byte)
    );

    sha256_ctrl #(
        .NUM_ROUNDS (NUM_ROUNDS)
    ) u_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_init     (cmd_init),
        .cmd_final    (cmd_final),
        .block_full   (block_full),
        .len_fits     (len_fits),
        .load         (load),
        .step         (step),
        .finish       (finish),
        .round        (round),
        .pad_mark     (pad_mark),
        .pad_fill     (pad_fill),
        .pad_spill    (pad_spill),
        .pad_len_only (pad_len_only),
        .busy         (busy),
        .done         (done),
        .irq          (irq)
    );

    sha256_block_buffer u_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd_init     (cmd_init),
        .din_wr       (din_wr),
        .din_byte     (din_byte),
        .pad_mark     (pad_mark),
        .pad_fill     (pad_fill),
        .pad_spill    (pad_spill),
        .pad_len_only (pad_len_only),
        .load         (load),
        .block        (block),
        .block_full   (block_full),
        .len_fits     (len_fits)
    );

    sha256_msg_schedule u_schedule (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .block (block),
        .step  (step),
        .round (round),
        .w_cur (w_cur)
    );

    sha256_round_core u_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_init (cmd_init),
        .load     (load),
        .step     (step),
        .finish   (finish),
        .round    (round),
        .w_cur    (w_cur),
        .digest   (digest)
    );

endmodule

// File: tb_sha256_accel.sv
// ============================================================
// Testbench for the SHA-256 accelerator
// Reads message vectors and expected digests from a data file
// Drives the register bus, checks STATUS, irq and the digest
// ============================================================

`timescale 1ns/1ps

module tb_sha256_accel
    import sha256_pkg::*;
;

    localparam int STIM_DEPTH = 1024;
    // Record header: mode byte, length byte, 32 digest bytes
    localparam int HDR_BYTES  = 34;

    logic      clk;
    logic      rst_n;
    logic      req;
    reg_addr_t addr;
    bus_data_t wdata;
    logic      wen;
    bus_data_t rdata;
    logic      ack;
    logic      irq;

    byte_t stim_mem [0:STIM_DEPTH-1];
    int    cycle_cnt     = 0;
    int    cycle_limit   = 0;
    int    last_wr_cycle = 0;
    int    irq_count     = 0;
    // req as taken by the last rising edge
    logic  req_q;

    sha256_accel #(
        .NUM_ROUNDS (64)
    ) uut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .addr  (addr),
        .wdata (wdata),
        .wen   (wen),
        .rdata (rdata),
        .ack   (ack),
        .irq   (irq)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ============================================================
    // Cycle counter, watchdog, irq pulse counter and ack monitor
    // ============================================================
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            abort_run($sformatf("Timeout: no result after %0d clock cycles", cycle_cnt));
        end
    end

    // irq is stable at the falling edge
    always @(negedge clk) begin
        if (irq) begin
            irq_count <= irq_count + 1;
        end
    end

    always @(posedge clk) begin
        req_q <= req;
    end

    // ack follows each request by one cycle and lasts one cycle
    always @(negedge clk) begin
        if (rst_n) begin
            check_ack(req_q);
        end
    end

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("TEST FAILED");
        $fatal(1, "Run stopped");
    endtask

    // ============================================================
    // Compare tasks
    // ============================================================
    task automatic check_word(input string name, input bus_data_t exp, input bus_data_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run("Bus data mismatch");
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("[ERROR] t=%0t %s expected %h got %h", $time, name, exp, act);
            abort_run("Digest byte mismatch");
        end
    endtask

    task automatic check_irq(input logic exp);
        if (irq !== exp) begin
            $display("[ERROR] t=%0t irq expected %b got %b", $time, exp, irq);
            abort_run("Interrupt level mismatch");
        end
    endtask

    task automatic check_ack(input logic exp);
        if (ack !== exp) begin
            $display("[ERROR] t=%0t ack expected %b got %b", $time, exp, ack);
            abort_run("Acknowledge timing mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] t=%0t %s expected %0d got %0d", $time, name, exp, act);
            abort_run("Pulse count mismatch");
        end
    endtask

    // ============================================================
    // Bus tasks, entered and left at a falling edge
    // ============================================================
    task automatic bus_write(input reg_addr_t a, input bus_data_t d);
        req   = 1'b1;
        wen   = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        // Count of the edge that took the write
        last_wr_cycle = cycle_cnt;
        req = 1'b0;
        wen = 1'b0;
        while (!ack) @(negedge clk);
        check_word("rdata on write", '0, rdata);
    endtask

    task automatic bus_read(input reg_addr_t a, output bus_data_t data);
        req  = 1'b1;
        wen  = 1'b0;
        addr = a;
        @(negedge clk);
        req = 1'b0;
        while (!ack) @(negedge clk);
        data = rdata;
    endtask

    task automatic wait_for_idle();
        bus_data_t rd;
        rd = 64'h1;
        while (rd[0]) begin
            bus_read(REG_STATUS, rd);
        end
    endtask

    // Busy from the edge after the 64th byte, falls on the 67th edge
    task automatic check_block_timing();
        int        wr_cycle;
        bus_data_t rd;
        wr_cycle = last_wr_cycle;
        bus_read(REG_STATUS, rd);
        check_word("STATUS after byte 64", 64'h1, rd);
        // Dropped by the register block while busy
        bus_write(REG_DIN, 64'h5a);
        while (cycle_cnt < wr_cycle + 66) @(negedge clk);
        // Sampled in the DONE cycle
        bus_read(REG_STATUS, rd);
        check_word("STATUS at edge 67 after byte 64", 64'h1, rd);
        bus_read(REG_STATUS, rd);
        check_word("STATUS at edge 68 after byte 64", 64'h0, rd);
    endtask

    // ============================================================
    // One vector: INIT, message bytes, FINAL, digest read-back
    // ============================================================
    task automatic hash_vector(input int base, input int num);
        byte_t     mode;
        int        len;
        bus_data_t rd;
        mode = stim_mem[base];
        len  = int'(stim_mem[base + 1]);
        bus_write(REG_CMD, bus_data_t'(CMD_INIT));
        bus_read(REG_STATUS, rd);
        check_word($sformatf("STATUS after INIT, vector %0d", num), 64'h0, rd);
        // Top byte of the initial H0
        bus_read(REG_DOUT_FIRST, rd);
        check_byte($sformatf("DOUT byte 0 after INIT, vector %0d", num), 8'h6a, rd[7:0]);
        for (int i = 0; i < len; i++) begin
            bus_write(REG_DIN, bus_data_t'(stim_mem[base + HDR_BYTES + i]));
            if (i % 64 == 63) begin
                if (mode == 8'h01 && i == 63) begin
                    check_block_timing();
                end else begin
                    wait_for_idle();
                end
            end
        end
        irq_count = 0;
        bus_write(REG_CMD, bus_data_t'(CMD_FINAL));
        while (!irq) @(negedge clk);
        bus_read(REG_STATUS, rd);
        check_word($sformatf("STATUS after FINAL, vector %0d", num), 64'h2, rd);
        check_irq(1'b0);
        for (int k = 0; k < 32; k++) begin
            bus_read(reg_addr_t'(REG_DOUT_FIRST + k), rd);
            check_byte($sformatf("DOUT byte %0d, vector %0d", k, num),
                       stim_mem[base + 2 + k], rd[7:0]);
        end
        check_count($sformatf("irq pulses, vector %0d", num), 1, irq_count);
    endtask

    // ============================================================
    // Main sequence
    // ============================================================
    initial begin : stimulus
        int        base;
        int        total_bytes;
        int        vec_count;
        bus_data_t rd;
        rst_n = 1'b0;
        req   = 1'b0;
        wen   = 1'b0;
        addr  = '0;
        wdata = '0;
        $readmemh("sha256_stimulus.txt", stim_mem);
        if ($isunknown(stim_mem[0])) begin
            abort_run("Stimulus file sha256_stimulus.txt could not be read");
        end
        // Walk the records once to size the cycle limit
        base        = 0;
        total_bytes = 0;
        vec_count   = 0;
        while (base < STIM_DEPTH && stim_mem[base] != 8'hff) begin
            total_bytes = total_bytes + int'(stim_mem[base + 1]);
            vec_count   = vec_count + 1;
            base        = base + HDR_BYTES + int'(stim_mem[base + 1]);
        end
        if (vec_count == 0) begin
            abort_run("No vectors found in the stimulus file");
        end
        cycle_limit = 200 * total_bytes + 2000;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;

        // Idle state after reset
        check_irq(1'b0);
        bus_read(REG_STATUS, rd);
        check_word("STATUS after reset", 64'h0, rd);
        bus_read(6'h38, rd);
        check_word("read of unmapped offset 0x38", 64'h0, rd);
        bus_read(REG_DIN, rd);
        check_word("read of DIN", 64'h0, rd);

        base = 0;
        for (int v = 0; v < vec_count; v++) begin
            hash_vector(base, v);
            base = base + HDR_BYTES + int'(stim_mem[base + 1]);
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: sha256_stimulus.txt
// Record: mode, message length, 32 expected digest bytes, then the message bytes
// Mode 01 checks busy timing and a dropped DIN write after byte 64; ff ends the list
00 00
e3 b0 c4 42 98 fc 1c 14 9a fb f4 c8 99 6f b9 24 27 ae 41 e4 64 9b 93 4c a4 95 99 1b 78 52 b8 55
00 03
ba 78 16 bf 8f 01 cf ea 41 41 40 de 5d ae 22 23 b0 03 61 a3 96 17 7a 9c b4 10 ff 61 f2 00 15 ad
61 62 63
00 2b
d7 a8 fb b3 07 d7 80 94 69 ca 9a bc b0 08 2e 4f 8d 56 51 e4 6d 3c db 76 2d 02 d0 bf 37 c9 e5 92
54 68 65 20 71 75 69 63 6b 20 62 72 6f 77 6e 20 66 6f 78 20 6a 75 6d 70 73 20 6f 76 65 72 20 74
68 65 20 6c 61 7a 79 20 64 6f 67
00 38
24 8d 6a 61 d2 06 38 b8 e5 c0 26 93 0c 3e 60 39 a3 3c e4 59 64 ff 21 67 f6 ec ed d4 19 db 06 c1
61 62 63 64 62 63 64 65 63 64 65 66 64 65 66 67 65 66 67 68 66 67 68 69 67 68 69 6a 68 69 6a 6b
69 6a 6b 6c 6a 6b 6c 6d 6b 6c 6d 6e 6c 6d 6e 6f 6d 6e 6f 70 6e 6f 70 71
01 40
f5 a5 fd 42 d1 6a 20 30 27 98 ef 6e d3 09 97 9b 43 00 3d 23 20 d9 f0 e8 ea 98 31 a9 27 59 fb 4b
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
01 70
cf 5b 16 a7 78 af 83 80 03 6c e5 9e 7b 04 92 37 0b 24 9b 11 e8 f0 7a 51 af ac 45 03 7a fe e9 d1
61 62 63 64 65 66 67 68 62 63 64 65 66 67 68 69 63 64 65 66 67 68 69 6a 64 65 66 67 68 69 6a 6b
65 66 67 68 69 6a 6b 6c 66 67 68 69 6a 6b 6c 6d 67 68 69 6a 6b 6c 6d 6e 68 69 6a 6b 6c 6d 6e 6f
69 6a 6b 6c 6d 6e 6f 70 6a 6b 6c 6d 6e 6f 70 71 6b 6c 6d 6e 6f 70 71 72 6c 6d 6e 6f 70 71 72 73
6d 6e 6f 70 71 72 73 74 6e 6f 70 71 72 73 74 75
ff

// File: verilog.f
sha256_pkg.sv
sha256_mmio_regs.sv
sha256_ctrl.sv
sha256_block_buffer.sv
sha256_msg_schedule.sv
sha256_round_core.sv
sha256_accel.sv
tb_sha256_accel.sv
